// ==== src.f ====
+incdir+verification
verilog/id_pkg.sv
verilog/instr_decoder.sv
verilog/imm_extender.sv
verilog/reg_file.sv
verilog/branch_predictor.sv
verilog/pc_redirect.sv
verilog/id_stage.sv
verification/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator and run, exit status follows the simulation
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module id_stage_tb -f src.f -o id_sim \
    && ./obj_dir/id_sim \
    && echo "simulation run ok" \
    || { echo "simulation run failed"; exit 1; }

// ==== verification/id_tests.svh ====
// ==============================
// instruction encoders
// ==============================
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm[31:12], rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// jalr lands on rs1 + imm with bit 0 dropped
function automatic logic [31:0] jalr_target(input logic [31:0] rs1, input logic [31:0] imm);
    return (rs1 + imm) & ~32'd1;
endfunction

// ==============================
// drive helpers
// ==============================
task automatic wb_write(input logic [4:0] rd, input logic [31:0] data);
    @(posedge clk);
    wb_en_i   <= 1'b1;
    wb_rd_i   <= rd;
    wb_data_i <= data;
    @(posedge clk);
    wb_en_i <= 1'b0;
    if (rd != 5'd0)
        mirror[rd] = data;   // x0 stays zero
endtask

// one enabled cycle, then hold with a nop so the results can be checked
task automatic decode_with(input logic [31:0] instr, input logic dep, input logic redir,
                           input logic [31:0] redir_pc, input logic exp_taken,
                           input logic [31:0] exp_target);
    logic [31:0] this_pc;
    this_pc = exp_pc;
    @(posedge clk);
    instruction_i   <= instr;
    enable_i        <= 1'b1;
    rs1_depended_i  <= dep;
    redirect_e_i    <= redir;
    redirect_pc_e_i <= redir_pc;
    @(negedge clk);
    check("taken_o", 32'(taken_o), 32'(exp_taken));
    if (exp_taken)
        check("redirect_pc_o", redirect_pc_o, exp_target);
    @(posedge clk);
    instruction_i  <= NOP;
    enable_i       <= 1'b0;
    rs1_depended_i <= 1'b0;
    redirect_e_i   <= 1'b0;
    @(negedge clk);
    check("pc_o", pc_o, this_pc);
    check("pc_next_o", pc_next_o, this_pc + 32'd4);
    exp_pc = exp_taken ? exp_target : this_pc + 32'd4;
endtask

task automatic decode(input logic [31:0] instr, input logic exp_taken,
                      input logic [31:0] exp_target);
    decode_with(instr, 1'b0, 1'b0, '0, exp_taken, exp_target);
endtask

// ==============================
// directed tests
// ==============================
task automatic test_reset();
    for (int i = 0; i < 32; i++)
        mirror[i] = '0;
    repeat (8) @(posedge clk);
    resetn   <= 1'b1;
    enable_i <= 1'b1;          // decode straight out of reset
    @(negedge clk);
    check("reg_write_o", 32'(reg_write_o), 32'd0);
    check("is_branch_o", 32'(is_branch_o), 32'd0);
    check("is_jalr_o", 32'(is_jalr_o), 32'd0);
    check("pred_taken_o", 32'(pred_taken_o), 32'd0);
    check("illegal_o", 32'(illegal_o), 32'd0);
    check("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    check("pred_pc_o", pred_pc_o, RESET_PC);
    check("op_a_o", op_a_o, 32'd0);
    check("taken_o", 32'(taken_o), 32'd1);
    check("redirect_pc_o", redirect_pc_o, RESET_PC);
    exp_pc = RESET_PC;
    decode(NOP, 1'b0, '0);
    check("pc_o", pc_o, RESET_PC);
    decode(NOP, 1'b0, '0);
    check("pc_o", pc_o, RESET_PC + 32'd4);
endtask

task automatic test_regs_operands();
    for (int r = 1; r < 32; r++)
        wb_write(5'(r), $random(seed));
    decode(enc_r(7'd0, 5'd7, 5'd5, 3'b000, 5'd3, OPC_OP), 1'b0, '0);   // add x3, x5, x7
    check("op_a_o", op_a_o, mirror[5]);
    check("op_b_o", op_b_o, mirror[7]);
    check("rd_idx_o", 32'(rd_idx_o), 32'd3);
    check("alu_op_o", 32'(alu_op_o), 32'(ALU_ADD));
    decode(enc_i(32'hffff_fffb, 5'd6, 3'b000, 5'd4, OPC_OP_IMM), 1'b0, '0);
    check("op_a_o", op_a_o, mirror[6]);
    check("op_b_o", op_b_o, 32'hffff_fffb);
    decode(enc_u(32'h1234_5000, 5'd8, OPC_AUIPC), 1'b0, '0);
    check("op_a_o", op_a_o, exp_pc - 32'd4);
    check("op_b_o", op_b_o, 32'h1234_5000);
    wb_write(5'd0, $random(seed));
    decode(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd1, OPC_OP), 1'b0, '0);
    check("op_a_o", op_a_o, 32'd0);
    check("op_b_o", op_b_o, 32'd0);
endtask

task automatic test_imm_fields();
    decode(enc_u(32'hfedc_b000, 5'd9, OPC_LUI), 1'b0, '0);
    check("imm_o", imm_o, 32'hfedc_b000);
    check("alu_op_o", 32'(alu_op_o), 32'(ALU_PASS_B));
    check("wb_src_o", 32'(wb_src_o), 32'(WB_ALU));
    check("reg_write_o", 32'(reg_write_o), 32'd1);
    decode(enc_s(32'hffff_fff4, 5'd7, 5'd2, 3'b010), 1'b0, '0);            // sw x7, -12(x2)
    check("imm_o", imm_o, 32'hffff_fff4);
    check("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_SW));
    check("reg_write_o", 32'(reg_write_o), 32'd0);
    check("rs2_data_o", rs2_data_o, mirror[7]);
    check("op_a_o", op_a_o, mirror[2]);
    decode(enc_i(32'h0000_07fc, 5'd3, 3'b010, 5'd10, OPC_LOAD), 1'b0, '0);
    check("imm_o", imm_o, 32'h0000_07fc);
    check("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_LW));
    check("wb_src_o", 32'(wb_src_o), 32'(WB_MEM));
    check("reg_write_o", 32'(reg_write_o), 32'd1);
    decode(enc_b(32'h0000_0ffc, 5'd2, 5'd1, 3'b001), 1'b0, '0);            // bne, forward
    check("imm_o", imm_o, 32'h0000_0ffc);
    check("is_branch_o", 32'(is_branch_o), 32'd1);
    check("alu_op_o", 32'(alu_op_o), 32'(ALU_BNE));
    check("reg_write_o", 32'(reg_write_o), 32'd0);
    decode(enc_j(32'hfff8_0a44, 5'd1), 1'b1, exp_pc + 32'hfff8_0a44);
    check("imm_o", imm_o, 32'hfff8_0a44);
    check("wb_src_o", 32'(wb_src_o), 32'(WB_PC4));
    check("reg_write_o", 32'(reg_write_o), 32'd1);
endtask

task automatic test_prediction();
    decode(enc_b(32'hffff_fff0, 5'd2, 5'd1, 3'b000), 1'b1, exp_pc - 32'd16);   // loop back
    check("pred_taken_o", 32'(pred_taken_o), 32'd1);
    check("pred_pc_o", pred_pc_o, exp_pc);
    decode(enc_b(32'h0000_0018, 5'd4, 5'd3, 3'b100), 1'b0, '0);
    check("pred_taken_o", 32'(pred_taken_o), 32'd0);
    decode(enc_j(32'h0000_0040, 5'd0), 1'b1, exp_pc + 32'h40);
    wb_write(5'd5, 32'h8000_1234);
    decode(enc_i(32'h5, 5'd5, 3'b000, 5'd1, OPC_JALR), 1'b1, jalr_target(mirror[5], 32'h5));
    check("is_jalr_o", 32'(is_jalr_o), 32'd1);
    check("pred_pc_o", pred_pc_o, 32'h8000_1238);
    // rs1 still in flight, no guess
    decode_with(enc_i(32'h5, 5'd5, 3'b000, 5'd1, OPC_JALR), 1'b1, 1'b0, '0, 1'b0, '0);
    check("pred_taken_o", 32'(pred_taken_o), 32'd0);
endtask

task automatic test_stall_flush();
    decode(enc_i(32'h55, 5'd0, 3'b000, 5'd11, OPC_OP_IMM), 1'b0, '0);
    repeat (4) begin
        @(posedge clk);
        instruction_i <= enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd12, OPC_OP);
        @(negedge clk);
        check("op_b_o", op_b_o, 32'h55);
        check("rd_idx_o", 32'(rd_idx_o), 32'd11);
        check("reg_write_o", 32'(reg_write_o), 32'd1);
        check("pc_o", pc_o, exp_pc - 32'd4);
    end
    decode(enc_j(32'h0000_0100, 5'd1), 1'b1, exp_pc + 32'h100);
    check("pred_taken_o", 32'(pred_taken_o), 32'd1);
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    @(negedge clk);
    check("reg_write_o", 32'(reg_write_o), 32'd0);
    check("pred_taken_o", 32'(pred_taken_o), 32'd0);
    // exe correction beats the backward-branch guess
    decode_with(enc_b(32'hffff_ffe0, 5'd2, 5'd1, 3'b000), 1'b0, 1'b1, 32'h8000_4000,
                1'b1, 32'h8000_4000);
    decode(NOP, 1'b0, '0);
endtask

task automatic test_illegal();
    decode(enc_i(32'h123, 5'd1, 3'b000, 5'd5, 7'b1111111), 1'b0, '0);
    check("illegal_o", 32'(illegal_o), 32'd1);
    check("reg_write_o", 32'(reg_write_o), 32'd0);
    check("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    decode(enc_i(32'h8, 5'd1, 3'b011, 5'd6, OPC_LOAD), 1'b0, '0);         // no ld in rv32i
    check("illegal_o", 32'(illegal_o), 32'd1);
    check("reg_write_o", 32'(reg_write_o), 32'd0);
    check("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    decode(NOP, 1'b0, '0);
    check("illegal_o", 32'(illegal_o), 32'd0);
endtask

// ==== verification/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] NOP            = 32'h0000_0013;   // addi x0, x0, 0

    // ==============================
    // dut signals
    // ==============================
    logic                  clk;
    logic                  resetn;
    logic                  enable_i;
    logic                  flush_i;
    logic                  redirect_e_i;
    logic                  rs1_depended_i;
    logic                  wb_en_i;
    logic [XLEN-1:0]       instruction_i;
    logic [XLEN-1:0]       redirect_pc_e_i;
    logic [XLEN-1:0]       wb_data_i;
    logic [REG_ADDR_W-1:0] wb_rd_i;

    logic                  taken_o;
    logic [XLEN-1:0]       redirect_pc_o;
    alu_op_t               alu_op_o;
    logic [XLEN-1:0]       op_a_o, op_b_o, rs2_data_o, imm_o;
    logic [XLEN-1:0]       pred_pc_o, pc_o, pc_next_o;
    logic [REG_ADDR_W-1:0] rd_idx_o;
    logic                  reg_write_o, is_branch_o, is_jalr_o, pred_taken_o, illegal_o;
    wb_src_t               wb_src_o;
    dmem_type_t            dmem_type_o;

    // reference state
    integer                seed;
    int                    cycle_cnt = 0;
    logic [31:0]           exp_pc;          // pc of the next decoded instruction
    logic [31:0]           mirror [32];

    id_stage dut_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, DUT stopped making progress", cycle_cnt);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    `include "id_tests.svh"

    initial begin
        seed = 32'hb83a_f96e;
        clk  = 1'b0;
        resetn          <= 1'b0;
        enable_i        <= 1'b0;
        flush_i         <= 1'b0;
        redirect_e_i    <= 1'b0;
        redirect_pc_e_i <= '0;
        rs1_depended_i  <= 1'b0;
        wb_en_i         <= 1'b0;
        wb_rd_i         <= '0;
        wb_data_i       <= '0;
        instruction_i   <= NOP;

        test_reset();
        test_regs_operands();
        test_imm_fields();
        test_prediction();
        test_stall_flush();
        test_illegal();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  enable_i,
    input  logic                  flush_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  logic                  redirect_e_i,
    input  logic [XLEN-1:0]       redirect_pc_e_i,
    input  logic                  rs1_depended_i,
    input  logic                  wb_en_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    // to fetch
    output logic                  taken_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    // decode/execute register
    output alu_op_t               alu_op_o,
    output logic [XLEN-1:0]       op_a_o,
    output logic [XLEN-1:0]       op_b_o,
    output logic [XLEN-1:0]       rs2_data_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [REG_ADDR_W-1:0] rd_idx_o,
    output logic                  reg_write_o,
    output wb_src_t               wb_src_o,
    output dmem_type_t            dmem_type_o,
    output logic                  is_branch_o,
    output logic                  is_jalr_o,
    output logic                  pred_taken_o,
    output logic [XLEN-1:0]       pred_pc_o,
    output logic [XLEN-1:0]       pc_o,
    output logic [XLEN-1:0]       pc_next_o,
    output logic                  illegal_o
);

    // ==============================
    // decode
    // ==============================
    alu_op_t         alu_op;
    op_a_sel_t       op_a_sel;
    op_b_sel_t       op_b_sel;
    imm_type_t       imm_type;
    dmem_type_t      dmem_type;
    wb_src_t         wb_src;
    logic            is_branch, is_jal, is_jalr, wb_en, illegal;
    logic [XLEN-1:0] imm, rs1_data, rs2_data;
    logic [XLEN-1:0] pc_cur, pc_next_cur, pred_pc;
    logic            pred_taken;
    logic [XLEN-1:0] op_a, op_b;

    instr_decoder u_decoder (
        .instr_i     (instruction_i),
        .alu_op_o    (alu_op),
        .op_a_sel_o  (op_a_sel),
        .op_b_sel_o  (op_b_sel),
        .imm_type_o  (imm_type),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .dmem_type_o (dmem_type),
        .wb_src_o    (wb_src),
        .wb_en_o     (wb_en),
        .illegal_o   (illegal)
    );

    imm_extender u_imm (
        .instr_i    (instruction_i),
        .imm_type_i (imm_type),
        .imm_o      (imm)
    );

    reg_file u_regs (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_addr_i (instruction_i[19:15]),
        .rs2_addr_i (instruction_i[24:20]),
        .rd_addr_i  (wb_rd_i),
        .rd_data_i  (wb_data_i),
        .rd_wr_en_i (wb_en_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    branch_predictor u_bp (
        .is_branch_i    (is_branch),
        .is_jal_i       (is_jal),
        .is_jalr_i      (is_jalr),
        .rs1_data_i     (rs1_data),
        .imm_i          (imm),
        .pc_i           (pc_cur),
        .rs1_depended_i (rs1_depended_i),
        .pred_taken_o   (pred_taken),
        .pred_pc_o      (pred_pc)
    );

    pc_redirect u_pc (
        .clk             (clk),
        .resetn          (resetn),
        .enable_i        (enable_i),
        .pred_taken_i    (pred_taken),
        .pred_pc_i       (pred_pc),
        .redirect_e_i    (redirect_e_i),
        .redirect_pc_e_i (redirect_pc_e_i),
        .flush_i         (flush_i),
        .pc_o            (pc_cur),
        .pc_next_o       (pc_next_cur),
        .taken_o         (taken_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    // operand select
    assign op_a = (op_a_sel == OPA_PC) ? pc_cur : rs1_data;
    assign op_b = (op_b_sel == OPB_IMM) ? imm : rs2_data;

    // ==============================
    // decode/execute register
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn || flush_i) begin
            alu_op_o     <= ALU_ADD;
            reg_write_o  <= 1'b0;
            wb_src_o     <= WB_ALU;
            dmem_type_o  <= DMEM_NONE;
            is_branch_o  <= 1'b0;
            is_jalr_o    <= 1'b0;
            pred_taken_o <= 1'b0;
            illegal_o    <= 1'b0;
        end else if (enable_i) begin
            alu_op_o     <= alu_op;
            reg_write_o  <= wb_en;
            wb_src_o     <= wb_src;
            dmem_type_o  <= dmem_type;
            is_branch_o  <= is_branch;
            is_jalr_o    <= is_jalr;
            pred_taken_o <= pred_taken;
            illegal_o    <= illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            op_a_o     <= '0;
            op_b_o     <= '0;
            rs2_data_o <= '0;
            imm_o      <= '0;
            rd_idx_o   <= '0;
            pred_pc_o  <= RESET_PC;
            pc_o       <= RESET_PC;
            pc_next_o  <= RESET_PC;
        end else if (enable_i) begin
            op_a_o     <= op_a;
            op_b_o     <= op_b;
            rs2_data_o <= rs2_data;    // store data
            imm_o      <= imm;
            rd_idx_o   <= instruction_i[11:7];
            pred_pc_o  <= pred_pc;
            pc_o       <= pc_cur;
            pc_next_o  <= pc_next_cur;
        end
    end

    a_no_illegal_write: assert property (
        @(posedge clk) disable iff (!resetn)
        !(reg_write_o && illegal_o)
    );

endmodule

// ==== verilog/pc_redirect.sv ====
`timescale 1ns/1ps

module pc_redirect import id_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            enable_i,
    input  logic            pred_taken_i,
    input  logic [XLEN-1:0] pred_pc_i,
    input  logic            redirect_e_i,
    input  logic [XLEN-1:0] redirect_pc_e_i,
    input  logic            flush_i,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] pc_next_o,
    output logic            taken_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic            rst_dly_q;    // first cycle out of reset
    logic            taken_q;      // redirect seen while stalled
    logic [XLEN-1:0] target_q;
    logic [XLEN-1:0] pc_q;

    assign pc_o      = pc_q;
    assign pc_next_o = pc_q + XLEN'(4);

    // priority: reset delay, exe correction, own prediction
    assign taken_o = rst_dly_q | redirect_e_i | (pred_taken_i & ~flush_i);

    always_comb begin
        if (rst_dly_q)
            redirect_pc_o = RESET_PC;
        else if (redirect_e_i)
            redirect_pc_o = redirect_pc_e_i;
        else
            redirect_pc_o = pred_pc_i;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rst_dly_q <= 1'b1;
            taken_q   <= 1'b0;
            target_q  <= RESET_PC;
            pc_q      <= RESET_PC;
        end else begin
            rst_dly_q <= 1'b0;
            if (enable_i) begin
                // next instruction comes from the redirect target if any
                if (taken_o)
                    pc_q <= redirect_pc_o;
                else
                    pc_q <= taken_q ? target_q : pc_next_o;
                taken_q <= 1'b0;
            end else if (taken_o) begin
                taken_q  <= 1'b1;       // keep it for the next enabled cycle
                target_q <= redirect_pc_o;
            end
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!resetn)
        pc_o[1:0] == 2'b00
    );

endmodule

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor import id_pkg::*; (
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            rs1_depended_i,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] pred_pc_o
);

    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] jalr_sum;
    logic            backward;

    assign pc_target = pc_i + imm_i;
    assign jalr_sum  = rs1_data_i + imm_i;
    assign backward  = imm_i[XLEN-1];   // negative offset, likely a loop

    // jalr can only be predicted once rs1 is final
    assign pred_taken_o = is_jal_i
                        | (is_branch_i & backward)
                        | (is_jalr_i & ~rs1_depended_i);

    assign pred_pc_o = is_jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : pc_target;

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import id_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic [XLEN-1:0]       rd_data_i,
    input  logic                  rd_wr_en_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr_en_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;   // x0 never written
        end
    end

    // combinational read, no write bypass
    // x0 keeps its reset zero
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!resetn)
        (rs1_addr_i == '0) |-> (rs1_data_o == '0)
    );

endmodule

// ==== verilog/imm_extender.sv ====
`timescale 1ns/1ps

module imm_extender import id_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    input  imm_type_t       imm_type_i,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            // b and j keep bit 0 at zero
            IMM_B: begin
                imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {instr_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;   // no immediate
        endcase
    end

endmodule

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import id_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    output alu_op_t         alu_op_o,
    output op_a_sel_t       op_a_sel_o,
    output op_b_sel_t       op_b_sel_o,
    output imm_type_t       imm_type_o,
    output logic            is_branch_o,
    output logic            is_jal_o,
    output logic            is_jalr_o,
    output dmem_type_t      dmem_type_o,
    output wb_src_t         wb_src_o,
    output logic            wb_en_o,
    output logic            illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // defaults: reg-reg op, nothing written
        alu_op_o    = ALU_ADD;
        op_a_sel_o  = OPA_RS1;
        op_b_sel_o  = OPB_RS2;
        imm_type_o  = IMM_NONE;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        dmem_type_o = DMEM_NONE;
        wb_src_o    = WB_ALU;
        wb_en_o     = 1'b0;
        illegal_o   = 1'b0;

        case (opcode)
            OPC_LUI: begin
                alu_op_o   = ALU_PASS_B;
                op_b_sel_o = OPB_IMM;
                imm_type_o = IMM_U;
                wb_en_o    = 1'b1;
            end
            OPC_AUIPC: begin
                op_a_sel_o = OPA_PC;
                op_b_sel_o = OPB_IMM;
                imm_type_o = IMM_U;
                wb_en_o    = 1'b1;
            end
            OPC_JAL: begin
                op_a_sel_o = OPA_PC;       // pc + imm as target
                op_b_sel_o = OPB_IMM;
                imm_type_o = IMM_J;
                is_jal_o   = 1'b1;
                wb_src_o   = WB_PC4;       // link
                wb_en_o    = 1'b1;
            end
            OPC_JALR: begin
                op_b_sel_o = OPB_IMM;
                imm_type_o = IMM_I;
                is_jalr_o  = 1'b1;
                wb_src_o   = WB_PC4;
                wb_en_o    = 1'b1;
                illegal_o  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_type_o  = IMM_B;
                is_branch_o = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = ALU_BEQ;
                    3'b001:  alu_op_o = ALU_BNE;
                    3'b100:  alu_op_o = ALU_BLT;
                    3'b101:  alu_op_o = ALU_BGE;
                    3'b110:  alu_op_o = ALU_BLTU;
                    3'b111:  alu_op_o = ALU_BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                op_b_sel_o = OPB_IMM;
                imm_type_o = IMM_I;
                wb_src_o   = WB_MEM;
                wb_en_o    = 1'b1;
                case (funct3)
                    3'b000:  dmem_type_o = DMEM_LB;
                    3'b001:  dmem_type_o = DMEM_LH;
                    3'b010:  dmem_type_o = DMEM_LW;
                    3'b100:  dmem_type_o = DMEM_LBU;
                    3'b101:  dmem_type_o = DMEM_LHU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_STORE: begin
                op_b_sel_o = OPB_IMM;      // address = rs1 + imm
                imm_type_o = IMM_S;
                case (funct3)
                    3'b000:  dmem_type_o = DMEM_SB;
                    3'b001:  dmem_type_o = DMEM_SH;
                    3'b010:  dmem_type_o = DMEM_SW;
                    default: illegal_o = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                op_b_sel_o = OPB_IMM;
                imm_type_o = IMM_I;
                wb_en_o    = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    3'b001: begin
                        alu_op_o  = ALU_SLL;
                        illegal_o = (funct7 != 7'b0);
                    end
                    default: begin // srli / srai
                        alu_op_o  = funct7[5] ? ALU_SRA : ALU_SRL;
                        illegal_o = ({funct7[6], funct7[4:0]} != 6'b0);
                    end
                endcase
            end
            OPC_OP: begin
                wb_en_o = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op_o = ALU_SLL;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b101: alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: alu_op_o = ALU_OR;
                    default: alu_op_o = ALU_AND;
                endcase
                // funct7[5] only valid for sub and sra
                if ({funct7[6], funct7[4:0]} != 6'b0)
                    illegal_o = 1'b1;
                if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)
                    illegal_o = 1'b1;
            end
            default: illegal_o = 1'b1;
        endcase

        // an illegal encoding must have no side effects
        if (illegal_o) begin
            wb_en_o     = 1'b0;
            dmem_type_o = DMEM_NONE;
            is_branch_o = 1'b0;
            is_jal_o    = 1'b0;
            is_jalr_o   = 1'b0;
        end
    end

endmodule

// ==== verilog/id_pkg.sv ====
package id_pkg;

    // ==============================
    // widths and reset values
    // ==============================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // ==============================
    // rv32i major opcodes
    // ==============================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ==============================
    // control field encodings
    // ==============================
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU   // branch compares
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_t;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_src_t;

    typedef enum logic [3:0] {
        DMEM_NONE, DMEM_LB, DMEM_LH, DMEM_LW, DMEM_LBU, DMEM_LHU,
        DMEM_SB, DMEM_SH, DMEM_SW
    } dmem_type_t;

    typedef enum logic {
        OPA_RS1, OPA_PC
    } op_a_sel_t;

    typedef enum logic {
        OPB_RS2, OPB_IMM
    } op_b_sel_t;

endpackage
